// File: design/soc_pkg.sv
/*
 * Shared bus types and the address map of the peripheral system.
 * Every window is 4 KiB and is matched by base and mask only.
 */
package soc_pkg;

  // Widths that carry a meaning on the bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // One request from the host, valid with its strobe
  typedef struct packed {
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // One response, valid one cycle after the request
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Device chosen by the address decoder
  typedef enum logic [1:0] {
    Ram,
    Gpio,
    Timer,
    None
  } dev_sel_e;

  // Address windows
  localparam addr_t RamBase   = 32'h0010_0000;
  localparam addr_t RamMask   = 32'hFFFF_F000;
  localparam addr_t GpioBase  = 32'h8000_0000;
  localparam addr_t GpioMask  = 32'hFFFF_F000;
  localparam addr_t TimerBase = 32'h8000_2000;
  localparam addr_t TimerMask = 32'hFFFF_F000;

  // Register offsets inside a window
  localparam logic [11:0] GpioOutOff    = 12'h000;
  localparam logic [11:0] GpioInOff     = 12'h004;
  localparam logic [11:0] TimerCountOff = 12'h000;
  localparam logic [11:0] TimerCmpOff   = 12'h004;
  localparam logic [11:0] TimerCtrlOff  = 12'h008;

  // Timer settings passed from the register block to the counter
  typedef struct packed {
    logic  en;
    data_t cmp;
  } timer_cfg_t;

endpackage

// File: design/bus_decode.sv
/*
 * Single host, no back-pressure: every strobe reaches one device or gets
 * an error response from the decoder one cycle later.
 */
`timescale 1ns/1ps

module bus_decode (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  input  soc_pkg::bus_rsp_t ram_rsp_i,
  input  logic              ram_valid_i,
  input  soc_pkg::bus_rsp_t gpio_rsp_i,
  input  logic              gpio_valid_i,
  input  soc_pkg::bus_rsp_t timer_rsp_i,
  input  logic              timer_valid_i,
  output logic              ram_req_o,
  output logic              gpio_req_o,
  output logic              timer_req_o,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);
  import soc_pkg::*;

  dev_sel_e sel;
  dev_sel_e sel_q;
  logic     unmapped_q;

  always_comb begin
    sel = None;
    if ((req_data_i.addr & RamMask) == RamBase) begin
      sel = Ram;
    end else if ((req_data_i.addr & GpioMask) == GpioBase) begin
      sel = Gpio;
    end else if ((req_data_i.addr & TimerMask) == TimerBase) begin
      sel = Timer;
    end
  end

  assign ram_req_o   = req_i && (sel == Ram);
  assign gpio_req_o  = req_i && (sel == Gpio);
  assign timer_req_o = req_i && (sel == Timer);

  // Selector and unmapped flag line up with the device responses
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      sel_q      <= None;
      unmapped_q <= 1'b0;
    end else begin
      sel_q      <= sel;
      unmapped_q <= req_i && (sel == None);
    end
  end

  assign rsp_valid_o = ram_valid_i || gpio_valid_i || timer_valid_i || unmapped_q;

  always_comb begin
    case (sel_q)
      Ram:     rsp_o = ram_rsp_i;
      Gpio:    rsp_o = gpio_rsp_i;
      Timer:   rsp_o = timer_rsp_i;
      default: rsp_o = '{rdata: '0, err: 1'b1};
    endcase
  end

endmodule

// File: design/scratch_ram.sv
/*
 * Single-port scratch RAM, RamDepth must be a power of two.
 * A write also returns the word as it was before the write.
 */
`timescale 1ns/1ps

module scratch_ram #(
  parameter int RamDepth = 1024
) (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              req_i,
  input  soc_pkg::bus_req_t req_data_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);
  import soc_pkg::*;

  localparam int IdxWidth = $clog2(RamDepth);

  data_t               mem [RamDepth];
  data_t               rdata_q;
  logic [IdxWidth-1:0] idx;

  // Word index wraps inside the window
  assign idx = req_data_i.addr[IdxWidth+1:2];

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_q <= mem[idx];
      for (int b = 0; b < 4; b++) begin
        if (req_data_i.we && req_data_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_i;
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: 1'b0};

endmodule

// File: design/gpio.sv
/*
 * GPIO with a byte-writable output register and synchronized inputs.
 * Both widths must be 32 bits or less.
 */
`timescale 1ns/1ps

module gpio #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,
  input  logic                req_i,
  input  soc_pkg::bus_req_t   req_data_i,
  input  logic [GpiWidth-1:0] gp_i,
  output logic                rsp_valid_o,
  output soc_pkg::bus_rsp_t   rsp_o,
  output logic [GpoWidth-1:0] gp_o
);
  import soc_pkg::*;

  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  logic [11:0]         offset;
  data_t               rdata_q;
  logic                err_q;

  assign offset = req_data_i.addr[11:0];

  // Two-flop synchronizer and output register
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q  <= '0;
      gpi_sync_q  <= '0;
      gp_o        <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      gpi_meta_q  <= gp_i;
      gpi_sync_q  <= gpi_meta_q;
      rsp_valid_o <= req_i;
      if (req_i && req_data_i.we && (offset == GpioOutOff)) begin
        for (int i = 0; i < GpoWidth; i++) begin
          if (req_data_i.be[i/8]) begin
            gp_o[i] <= req_data_i.wdata[i];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      err_q   <= !((offset == GpioOutOff) || (offset == GpioInOff));
      rdata_q <= '0;
      if (offset == GpioOutOff) begin
        rdata_q <= data_t'(gp_o);
      end else if (offset == GpioInOff) begin
        rdata_q <= data_t'(gpi_sync_q);
      end
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q};

endmodule

// File: design/timer_regs.sv
/*
 * Timer register block: count, compare and control (enable in bit 0).
 * Count and compare writes honour the byte enables.
 */
`timescale 1ns/1ps

module timer_regs (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,
  input  logic                req_i,
  input  soc_pkg::bus_req_t   req_data_i,
  input  soc_pkg::data_t      count_i,
  output logic                rsp_valid_o,
  output soc_pkg::bus_rsp_t   rsp_o,
  output soc_pkg::timer_cfg_t cfg_o,
  output logic                count_wr_o,
  output soc_pkg::data_t      count_wdata_o
);
  import soc_pkg::*;

  timer_cfg_t  cfg_q;
  logic [11:0] offset;
  logic        wr;
  data_t       rdata_q;
  logic        err_q;

  assign offset = req_data_i.addr[11:0];
  assign wr     = req_i && req_data_i.we;

  // Merge the written bytes into the live count
  always_comb begin
    count_wdata_o = count_i;
    for (int b = 0; b < 4; b++) begin
      if (req_data_i.be[b]) begin
        count_wdata_o[8*b +: 8] = req_data_i.wdata[8*b +: 8];
      end
    end
  end

  assign count_wr_o = wr && (offset == TimerCountOff);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      cfg_q       <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_i;
      if (wr && (offset == TimerCmpOff)) begin
        for (int b = 0; b < 4; b++) begin
          if (req_data_i.be[b]) begin
            cfg_q.cmp[8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
      end
      if (wr && (offset == TimerCtrlOff) && req_data_i.be[0]) begin
        cfg_q.en <= req_data_i.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      err_q <= 1'b0;
      case (offset)
        TimerCountOff: rdata_q <= count_i;
        TimerCmpOff:   rdata_q <= cfg_q.cmp;
        TimerCtrlOff:  rdata_q <= data_t'(cfg_q.en);
        default: begin
          rdata_q <= '0;
          err_q   <= 1'b1;
        end
      endcase
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q};
  assign cfg_o = cfg_q;

endmodule

// File: design/timer_core.sv
/*
 * Free-running timer counter, a count write wins over the increment.
 * The interrupt is a level, held while enabled and count >= compare.
 */
`timescale 1ns/1ps

module timer_core (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,
  input  soc_pkg::timer_cfg_t cfg_i,
  input  logic                count_wr_i,
  input  soc_pkg::data_t      count_wdata_i,
  output soc_pkg::data_t      count_o,
  output logic                irq_o
);
  import soc_pkg::*;

  data_t count_q;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      count_q <= '0;
    end else if (count_wr_i) begin
      count_q <= count_wdata_i;
    end else if (cfg_i.en) begin
      count_q <= count_q + 32'd1;
    end
  end

  assign count_o = count_q;

  // Unsigned compare, wraps with the counter
  assign irq_o = cfg_i.en && (count_q >= cfg_i.cmp);

endmodule

// File: design/demo_soc.sv
/*
 * Peripheral system with one bus host: RAM, GPIO and timer on clk_sys_i.
 * Each request strobe gets exactly one response in the next cycle.
 */
`timescale 1ns/1ps

module demo_soc #(
  parameter int RamDepth = 1024,
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,
  input  logic                req_i,
  input  soc_pkg::bus_req_t   req_data_i,
  input  logic [GpiWidth-1:0] gp_i,
  output logic                rsp_valid_o,
  output soc_pkg::bus_rsp_t   rsp_o,
  output logic [GpoWidth-1:0] gp_o,
  output logic                timer_irq_o
);
  import soc_pkg::*;

  // Device request strobes
  logic ram_req;
  logic gpio_req;
  logic timer_req;

  // Device responses
  logic     ram_valid;
  logic     gpio_valid;
  logic     timer_valid;
  bus_rsp_t ram_rsp;
  bus_rsp_t gpio_rsp;
  bus_rsp_t timer_rsp;

  // Timer register block to counter
  timer_cfg_t timer_cfg;
  logic       count_wr;
  data_t      count_wdata;
  data_t      count;

  bus_decode u_bus_decode (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .req_i        (req_i),
    .req_data_i   (req_data_i),
    .ram_rsp_i    (ram_rsp),
    .ram_valid_i  (ram_valid),
    .gpio_rsp_i   (gpio_rsp),
    .gpio_valid_i (gpio_valid),
    .timer_rsp_i  (timer_rsp),
    .timer_valid_i(timer_valid),
    .ram_req_o    (ram_req),
    .gpio_req_o   (gpio_req),
    .timer_req_o  (timer_req),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

  scratch_ram #(
    .RamDepth(RamDepth)
  ) u_scratch_ram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (ram_req),
    .req_data_i (req_data_i),
    .rsp_valid_o(ram_valid),
    .rsp_o      (ram_rsp)
  );

  gpio #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (gpio_req),
    .req_data_i (req_data_i),
    .gp_i       (gp_i),
    .rsp_valid_o(gpio_valid),
    .rsp_o      (gpio_rsp),
    .gp_o       (gp_o)
  );

  timer_regs u_timer_regs (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .req_i        (timer_req),
    .req_data_i   (req_data_i),
    .count_i      (count),
    .rsp_valid_o  (timer_valid),
    .rsp_o        (timer_rsp),
    .cfg_o        (timer_cfg),
    .count_wr_o   (count_wr),
    .count_wdata_o(count_wdata)
  );

  timer_core u_timer_core (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .cfg_i        (timer_cfg),
    .count_wr_i   (count_wr),
    .count_wdata_i(count_wdata),
    .count_o      (count),
    .irq_o        (timer_irq_o)
  );

endmodule

// File: dv/soc_assert.sv
/*
 * Bus protocol assertions on demo_soc, attached by bind.
 */
`timescale 1ns/1ps

module soc_assert (
  input logic clk_sys_i,
  input logic rst_sys_ni,
  input logic req_i,
  input logic rsp_valid_i,
  input logic irq_i
);

  // Number of failed assertions
  int fail_cnt = 0;

  // One response in the cycle after each request, none at other times
  rsp_after_req: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) rsp_valid_i == $past(req_i)
  ) else begin
    fail_cnt++;
    $error("response valid does not follow the request by one cycle");
  end

  irq_low_after_reset: assert property (
    @(posedge clk_sys_i) $rose(rst_sys_ni) |-> !irq_i
  ) else begin
    fail_cnt++;
    $error("timer interrupt high right after reset");
  end

endmodule

bind demo_soc soc_assert soc_assert_i (
  .clk_sys_i  (clk_sys_i),
  .rst_sys_ni (rst_sys_ni),
  .req_i      (req_i),
  .rsp_valid_i(rsp_valid_o),
  .irq_i      (timer_irq_o)
);

// File: dv/soc_checker.sv
/*
 * Reference model of RAM, GPIO and timer, stepped on the falling clock edge.
 * Expects the testbench to read only RAM words that it has written before.
 */
`timescale 1ns/1ps

module soc_checker #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input logic                clk_sys_i,
  input logic                rst_sys_ni,
  input logic                req_i,
  input soc_pkg::bus_req_t   req_data_i,
  input logic                rsp_valid_i,
  input soc_pkg::bus_rsp_t   rsp_i,
  input logic [GpiWidth-1:0] gpi_i,
  input logic [GpoWidth-1:0] gpo_i,
  input logic                irq_i
);
  import soc_pkg::*;

  string               test_name = "reset";
  int                  check_cnt = 0;
  int                  err_cnt   = 0;
  data_t               ram_m [1024];
  logic [GpoWidth-1:0] gpo_m;
  logic [GpiWidth-1:0] meta_m;
  logic [GpiWidth-1:0] sync_m;
  data_t               cnt_m;
  data_t               cmp_m;
  logic                en_m;
  logic                pend;
  logic                pend_rd;
  bus_rsp_t            exp_rsp;

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t be);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic compare_value(input string what, input data_t exp, input data_t act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  always @(negedge clk_sys_i) begin
    logic [11:0] off;
    logic        wr;
    logic        in_ram;
    logic        in_gpio;
    logic        in_timer;
    if (!rst_sys_ni) begin
      gpo_m  = '0;
      meta_m = '0;
      sync_m = '0;
      cnt_m  = '0;
      cmp_m  = '0;
      en_m   = 1'b0;
      pend   = 1'b0;
    end else begin
      // Response to the request seen one falling edge earlier
      compare_value("rsp_valid_o", data_t'(pend), data_t'(rsp_valid_i));
      if (pend) begin
        compare_value("rsp_o.err", data_t'(exp_rsp.err), data_t'(rsp_i.err));
        if (pend_rd || exp_rsp.err) begin
          compare_value("rsp_o.rdata", exp_rsp.rdata, rsp_i.rdata);
        end
      end
      compare_value("gp_o", data_t'(gpo_m), data_t'(gpo_i));
      compare_value("timer_irq_o", data_t'(en_m && (cnt_m >= cmp_m)), data_t'(irq_i));

      // Expected response to the request taken at the next rising edge
      off      = req_data_i.addr[11:0];
      wr       = req_i && req_data_i.we;
      in_ram   = req_data_i.addr[31:12] == 20'h00100;
      in_gpio  = req_data_i.addr[31:12] == 20'h80000;
      in_timer = req_data_i.addr[31:12] == 20'h80002;
      pend     = req_i;
      pend_rd  = !req_data_i.we;
      exp_rsp  = '{rdata: '0, err: 1'b0};
      if (in_ram) begin
        exp_rsp.rdata = ram_m[req_data_i.addr[11:2]];
      end else if (in_gpio && off == 12'h000) begin
        exp_rsp.rdata = data_t'(gpo_m);
      end else if (in_gpio && off == 12'h004) begin
        exp_rsp.rdata = data_t'(sync_m);
      end else if (in_timer && off == 12'h000) begin
        exp_rsp.rdata = cnt_m;
      end else if (in_timer && off == 12'h004) begin
        exp_rsp.rdata = cmp_m;
      end else if (in_timer && off == 12'h008) begin
        exp_rsp.rdata = data_t'(en_m);
      end else begin
        exp_rsp.err = 1'b1;
      end

      // Model state after that rising edge
      sync_m = meta_m;
      meta_m = gpi_i;
      if (wr && in_ram) begin
        ram_m[req_data_i.addr[11:2]] = merge_bytes(ram_m[req_data_i.addr[11:2]],
                                                   req_data_i.wdata, req_data_i.be);
      end
      if (wr && in_gpio && off == 12'h000) begin
        gpo_m = GpoWidth'(merge_bytes(data_t'(gpo_m), req_data_i.wdata, req_data_i.be));
      end
      // A count write replaces the increment
      if (wr && in_timer && off == 12'h000) begin
        cnt_m = merge_bytes(cnt_m, req_data_i.wdata, req_data_i.be);
      end else if (en_m) begin
        cnt_m = cnt_m + 32'd1;
      end
      if (wr && in_timer && off == 12'h004) begin
        cmp_m = merge_bytes(cmp_m, req_data_i.wdata, req_data_i.be);
      end
      if (wr && in_timer && off == 12'h008 && req_data_i.be[0]) begin
        en_m = req_data_i.wdata[0];
      end
    end
  end

endmodule

// File: dv/tb_top.sv
/*
 * Testbench for demo_soc: random bus traffic from seed 92, one request per cycle
 * at most. Responses and pins are compared by soc_checker.
 */
`timescale 1ns/1ps

module tb_top;
  import soc_pkg::*;

  localparam int GpiWidth  = 8;
  localparam int GpoWidth  = 16;
  localparam int ClkPeriod = 8;
  localparam int RamWords  = 16;
  localparam int GpoWrites = 16;
  localparam int GpiReads  = 8;
  localparam int BadRounds = 8;
  // Transactions and idle cycles of all tests, used by the watchdog
  localparam int NumTxn    = 4*RamWords + 2*GpoWrites + GpiReads + 3*BadRounds + 9;
  localparam int MaxIdle   = 3*GpiReads + 20 + 40 + 6*2 + 5;

  localparam addr_t GpiAddr  = GpioBase + 32'h4;
  localparam addr_t CmpAddr  = TimerBase + 32'h4;
  localparam addr_t CtrlAddr = TimerBase + 32'h8;

  logic                clk_sys = 1'b0;
  logic                rst_sys_n;
  logic                req;
  bus_req_t            req_data;
  logic [GpiWidth-1:0] gp_in;
  logic                rsp_valid;
  bus_rsp_t            rsp;
  logic [GpoWidth-1:0] gp_out;
  logic                timer_irq;
  int                  tb_errs   = 0;
  int                  errs_seen = 0;
  int                  tests_run = 0;
  int                  total_errs;

  always #(ClkPeriod/2) clk_sys = ~clk_sys;

  demo_soc #(
    .RamDepth(1024),
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) demo_soc_i (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .req_i      (req),
    .req_data_i (req_data),
    .gp_i       (gp_in),
    .rsp_valid_o(rsp_valid),
    .rsp_o      (rsp),
    .gp_o       (gp_out),
    .timer_irq_o(timer_irq)
  );

  soc_checker #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) checker_i (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .req_i      (req),
    .req_data_i (req_data),
    .rsp_valid_i(rsp_valid),
    .rsp_i      (rsp),
    .gpi_i      (gp_in),
    .gpo_i      (gp_out),
    .irq_i      (timer_irq)
  );

  // Errors from the checker, the bound assertions and the testbench itself
  function automatic int error_total();
    return checker_i.err_cnt + demo_soc_i.soc_assert_i.fail_cnt + tb_errs;
  endfunction

  task automatic next_cycle();
    @(posedge clk_sys);
    #1;
  endtask

  // One-cycle strobe, then wait for the response
  task automatic bus_access(input logic we, input strb_t be, input addr_t addr,
                            input data_t wdata);
    int waited;
    waited   = 0;
    req      = 1'b1;
    req_data = '{we: we, be: be, addr: addr, wdata: wdata};
    next_cycle();
    req = 1'b0;
    while (!rsp_valid && waited < 4) begin
      next_cycle();
      waited++;
    end
    if (!rsp_valid) begin
      tb_errs++;
      $display("No response to the request at address %h", addr);
    end
  endtask

  task automatic begin_test(input string name);
    checker_i.test_name = name;
  endtask

  task automatic finish_test();
    int errs;
    // Let the checker see the last response
    repeat (2) next_cycle();
    errs      = error_total() - errs_seen;
    errs_seen = error_total();
    tests_run++;
    $display("Test %s done with %0d errors", checker_i.test_name, errs);
  endtask

  task automatic ram_test();
    addr_t addrs [$];
    repeat (RamWords) begin
      addrs.push_back(RamBase + addr_t'($urandom_range(0, 1023) * 4));
      bus_access(1'b1, 4'hF, addrs[$], $urandom());
    end
    repeat (RamWords) begin
      bus_access(1'b1, strb_t'($urandom_range(0, 15)), addrs[$urandom_range(0, RamWords-1)],
                 $urandom());
    end
    repeat (2*RamWords) begin
      bus_access(1'b0, 4'hF, addrs[$urandom_range(0, RamWords-1)], '0);
    end
  endtask

  task automatic gpo_test();
    repeat (GpoWrites) begin
      bus_access(1'b1, strb_t'($urandom_range(0, 15)), GpioBase, $urandom());
      bus_access(1'b0, 4'hF, GpioBase, '0);
    end
  endtask

  task automatic gpi_test();
    repeat (GpiReads) begin
      gp_in = GpiWidth'($urandom());
      // Covers the two synchronizer flops
      repeat (3) next_cycle();
      bus_access(1'b0, 4'hF, GpiAddr, '0);
    end
  endtask

  task automatic unmapped_test();
    addr_t addr;
    repeat (BadRounds) begin
      addr = $urandom();
      while (addr[31:12] inside {20'h00100, 20'h80000, 20'h80002}) begin
        addr = $urandom();
      end
      bus_access(1'($urandom_range(0, 1)), 4'hF, addr, $urandom());
      bus_access(1'($urandom_range(0, 1)), 4'hF,
                 GpioBase + addr_t'($urandom_range(2, 1023) * 4), $urandom());
      bus_access(1'($urandom_range(0, 1)), 4'hF,
                 TimerBase + addr_t'($urandom_range(3, 1023) * 4), $urandom());
    end
  endtask

  // Two count reads a random gap apart, the model tracks every increment
  task automatic count_test();
    int gap;
    gap = $urandom_range(5, 20);
    bus_access(1'b1, 4'hF, TimerBase, $urandom());
    bus_access(1'b1, 4'h1, CtrlAddr, 32'h1);
    bus_access(1'b0, 4'hF, TimerBase, '0);
    repeat (gap) next_cycle();
    bus_access(1'b0, 4'hF, TimerBase, '0);
    bus_access(1'b1, 4'h1, CtrlAddr, 32'h0);
  endtask

  task automatic irq_test();
    int waited;
    waited = 0;
    bus_access(1'b1, 4'hF, TimerBase, '0);
    bus_access(1'b1, 4'hF, CmpAddr, data_t'($urandom_range(10, 30)));
    bus_access(1'b1, 4'h1, CtrlAddr, 32'h1);
    while (!timer_irq && waited < 40) begin
      next_cycle();
      waited++;
    end
    if (!timer_irq) begin
      tb_errs++;
      $display("Timer interrupt did not rise within 40 cycles");
    end
    bus_access(1'b1, 4'h1, CtrlAddr, 32'h0);
  endtask

  initial begin
    void'($urandom(92));
    rst_sys_n = 1'b0;
    req       = 1'b0;
    req_data  = '0;
    gp_in     = '0;
    repeat (5) @(posedge clk_sys);
    #1;
    rst_sys_n = 1'b1;
    begin_test("ram");
    ram_test();
    finish_test();
    begin_test("gpio_out");
    gpo_test();
    finish_test();
    begin_test("gpio_in");
    gpi_test();
    finish_test();
    begin_test("unmapped");
    unmapped_test();
    finish_test();
    begin_test("timer_count");
    count_test();
    finish_test();
    begin_test("timer_irq");
    irq_test();
    finish_test();
    total_errs = error_total();
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checker_i.check_cnt, total_errs);
    if (total_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((NumTxn + MaxIdle + 100) * ClkPeriod);
    $display("Watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: list.f
design/soc_pkg.sv
design/bus_decode.sv
design/scratch_ram.sv
design/gpio.sv
design/timer_regs.sv
design/timer_core.sv
design/demo_soc.sv
dv/soc_assert.sv
dv/soc_checker.sv
dv/tb_top.sv

// File: Makefile
# Verilator build and run of the demo_soc testbench
TOP = tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
